/* hw/video_pkg.sv */
// Screen geometry, memory sizes and the palette word type that every video block refers to by scope
package video_pkg;

    // Horizontal raster in pixels
    localparam int h_visible = 48;
    localparam int h_total   = 64;
    localparam int hs_start  = 52;
    localparam int hs_width  = 4;

    // Vertical raster in lines
    localparam int v_visible = 32;
    localparam int v_total   = 40;
    localparam int vs_start  = 34;
    localparam int vs_width  = 2;

    // Counter widths, enough for h_total and v_total
    localparam int hpos_w = 6;
    localparam int vpos_w = 6;

    // Tilemaps, one byte per tile with bank in the high nibble
    localparam int char_cols = 8;
    localparam int char_rows = 4;
    localparam int scr_cols  = 16;
    localparam int scr_rows  = 8;

    // 16 tiles x 8 rows x 2 planes
    localparam int pat_bytes   = 256;
    localparam int pal_entries = 128;
    localparam int addr_w      = 10;

    // Raw view for CPU access, colour view for the pixel output
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic [3:0] r;
            logic [3:0] g;
            logic [3:0] b;
        } rgb;
    } pal_word_u;

endpackage

/* hw/video_if.sv */
// CPU bus and raster scan interfaces that connect the video blocks inside the top level
`timescale 1ns/1ps

interface cpu_bus_if;
    logic [video_pkg::addr_w-1:0] cpu_addr;
    logic                         cpu_wrn;
    logic [7:0]                   cpu_dout;

    // Each memory block only samples the shared bus
    modport consumer (
        input cpu_addr,
        input cpu_wrn,
        input cpu_dout
    );
endinterface

interface scan_if;
    logic                         pxl_cen;
    logic [video_pkg::hpos_w-1:0] hpos;
    logic [video_pkg::vpos_w-1:0] vpos;
    logic                         hbl;
    logic                         vbl;

    // Pixel enable comes from outside, position from the timing block
    modport source (
        input  pxl_cen,
        output hpos,
        output vpos,
        output hbl,
        output vbl
    );

    modport sink (
        input pxl_cen,
        input hpos,
        input vpos,
        input hbl,
        input vbl
    );
endinterface

/* hw/video_timing.sv */
// Raster timing generator that drives the scan interface and the sync outputs of the video top
`timescale 1ns/1ps

module video_timing (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   flip,
    scan_if.source scan,
    output logic   hs,
    output logic   vs
);

    logic [video_pkg::hpos_w-1:0] hcnt;
    logic [video_pkg::hpos_w-1:0] hnext;
    logic [video_pkg::vpos_w-1:0] vcnt;
    logic [video_pkg::vpos_w-1:0] vnext;
    logic                         line_end;
    int                           hmir;
    int                           vmir;

    assign line_end = int'(hcnt) == video_pkg::h_total - 1;
    assign hnext    = line_end ? '0 : hcnt + 1'b1;

    always_comb begin
        vnext = vcnt;
        if (line_end) begin
            if (int'(vcnt) == video_pkg::v_total - 1) begin
                vnext = '0;
            end else begin
                vnext = vcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt <= '0;
            vcnt <= '0;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (scan.pxl_cen) begin
            hcnt <= hnext;
            vcnt <= vnext;
            hs   <= int'(hnext) >= video_pkg::hs_start &&
                    int'(hnext) <  video_pkg::hs_start + video_pkg::hs_width;
            // vs only moves as a new line starts, while hs is low
            if (line_end) begin
                vs <= int'(vnext) >= video_pkg::vs_start &&
                      int'(vnext) <  video_pkg::vs_start + video_pkg::vs_width;
            end
        end
    end

    // Mirrored position for a flipped screen
    assign hmir = video_pkg::h_visible - 1 - int'(hcnt);
    assign vmir = video_pkg::v_visible - 1 - int'(vcnt);

    assign scan.hpos = flip ? hmir[video_pkg::hpos_w-1:0] : hcnt;
    assign scan.vpos = flip ? vmir[video_pkg::vpos_w-1:0] : vcnt;
    assign scan.hbl  = int'(hcnt) >= video_pkg::h_visible;
    assign scan.vbl  = int'(vcnt) >= video_pkg::v_visible;

endmodule

/* hw/char_layer.sv */
// Foreground character layer with CPU-writable tilemap and pattern RAM, feeding colmix
`timescale 1ns/1ps

module char_layer (
    input  logic        clk,
    input  logic        arst_n,
    cpu_bus_if.consumer bus,
    input  logic        char_cs,
    output logic [7:0]  char_dout,
    scan_if.sink        scan,
    output logic [5:0]  char_pxl
);

    logic [7:0] map_ram [video_pkg::char_cols*video_pkg::char_rows];
    // Bit-planes kept apart so both bytes of a row come out together
    logic [7:0] pat0 [video_pkg::pat_bytes/2];
    logic [7:0] pat1 [video_pkg::pat_bytes/2];

    logic [7:0] tile;
    logic [2:0] fine_x;
    logic [2:0] fine_y;
    logic [6:0] pat_idx;
    logic [7:0] plane0;
    logic [7:0] plane1;

    // CPU side, map at 0..31 and patterns at 256..511
    always_ff @(posedge clk) begin
        if (char_cs && !bus.cpu_wrn) begin
            if (bus.cpu_addr[8]) begin
                if (bus.cpu_addr[0]) begin
                    pat1[bus.cpu_addr[7:1]] <= bus.cpu_dout;
                end else begin
                    pat0[bus.cpu_addr[7:1]] <= bus.cpu_dout;
                end
            end else begin
                map_ram[bus.cpu_addr[4:0]] <= bus.cpu_dout;
            end
        end
        if (char_cs) begin
            if (bus.cpu_addr[8]) begin
                char_dout <= bus.cpu_addr[0] ? pat1[bus.cpu_addr[7:1]]
                                             : pat0[bus.cpu_addr[7:1]];
            end else begin
                char_dout <= map_ram[bus.cpu_addr[4:0]];
            end
        end
    end

    assign pat_idx = {tile[3:0], fine_y};
    assign plane0  = pat0[pat_idx];
    assign plane1  = pat1[pat_idx];

    // Stage one fetches the tile, stage two picks the pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tile     <= '0;
            fine_x   <= '0;
            fine_y   <= '0;
            char_pxl <= '0;
        end else if (scan.pxl_cen) begin
            tile     <= map_ram[{scan.vpos[4:3], scan.hpos[5:3]}];
            fine_x   <= scan.hpos[2:0];
            fine_y   <= scan.vpos[2:0];
            // Leftmost pixel sits in bit 7
            char_pxl <= {tile[7:4], plane1[~fine_x], plane0[~fine_x]};
        end
    end

endmodule

/* hw/scroll_layer.sv */
// Background scroll layer over a wrapping 128x64 plane, feeding colmix
`timescale 1ns/1ps

module scroll_layer (
    input  logic        clk,
    input  logic        arst_n,
    cpu_bus_if.consumer bus,
    input  logic        scr_cs,
    output logic [7:0]  scr_dout,
    scan_if.sink        scan,
    input  logic [6:0]  scroll_x,
    input  logic [5:0]  scroll_y,
    output logic [5:0]  scr_pxl
);

    logic [7:0] map_ram [video_pkg::scr_cols*video_pkg::scr_rows];
    logic [7:0] pat0 [video_pkg::pat_bytes/2];
    logic [7:0] pat1 [video_pkg::pat_bytes/2];

    logic [6:0] plane_x;
    logic [5:0] plane_y;
    logic [7:0] tile;
    logic [2:0] fine_x;
    logic [2:0] fine_y;
    logic [6:0] pat_idx;
    logic [7:0] plane0;
    logic [7:0] plane1;

    // CPU side, map at 0..127 and patterns at 256..511
    always_ff @(posedge clk) begin
        if (scr_cs && !bus.cpu_wrn) begin
            if (bus.cpu_addr[8]) begin
                if (bus.cpu_addr[0]) begin
                    pat1[bus.cpu_addr[7:1]] <= bus.cpu_dout;
                end else begin
                    pat0[bus.cpu_addr[7:1]] <= bus.cpu_dout;
                end
            end else begin
                map_ram[bus.cpu_addr[6:0]] <= bus.cpu_dout;
            end
        end
        if (scr_cs) begin
            if (bus.cpu_addr[8]) begin
                scr_dout <= bus.cpu_addr[0] ? pat1[bus.cpu_addr[7:1]]
                                            : pat0[bus.cpu_addr[7:1]];
            end else begin
                scr_dout <= map_ram[bus.cpu_addr[6:0]];
            end
        end
    end

    // Wrap comes for free from the adder widths
    assign plane_x = {1'b0, scan.hpos} + scroll_x;
    assign plane_y = scan.vpos + scroll_y;

    assign pat_idx = {tile[3:0], fine_y};
    assign plane0  = pat0[pat_idx];
    assign plane1  = pat1[pat_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tile    <= '0;
            fine_x  <= '0;
            fine_y  <= '0;
            scr_pxl <= '0;
        end else if (scan.pxl_cen) begin
            // 16 tiles across, 8 down
            tile    <= map_ram[{plane_y[5:3], plane_x[6:3]}];
            fine_x  <= plane_x[2:0];
            fine_y  <= plane_y[2:0];
            // Colour 0 is a real colour here
            scr_pxl <= {tile[7:4], plane1[~fine_x], plane0[~fine_x]};
        end
    end

endmodule

/* hw/colmix.sv */
// Colour mixer with layer priority, CPU palette RAM and blank masking, last stage of the video top
`timescale 1ns/1ps

module colmix (
    input  logic        clk,
    input  logic        arst_n,
    cpu_bus_if.consumer bus,
    input  logic        pal_cs,
    output logic [7:0]  pal_dout,
    scan_if.sink        scan,
    input  logic [5:0]  char_pxl,
    input  logic [5:0]  scr_pxl,
    input  logic [1:0]  layer_en,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        lhbl_dly,
    output logic        lvbl_dly
);

    video_pkg::pal_word_u pal_ram [video_pkg::pal_entries];
    video_pkg::pal_word_u sel_word;
    video_pkg::pal_word_u pix;

    logic [6:0] cpu_entry;
    logic [1:0] hbl_sr;
    logic [1:0] vbl_sr;
    logic       use_char;
    logic       use_scr;

    // Two bytes per entry, odd byte holds red
    assign cpu_entry = bus.cpu_addr[7:1];

    always_ff @(posedge clk) begin
        if (pal_cs && !bus.cpu_wrn) begin
            if (bus.cpu_addr[0]) begin
                pal_ram[cpu_entry].rgb.r <= bus.cpu_dout[3:0];
            end else begin
                pal_ram[cpu_entry].raw[7:0] <= bus.cpu_dout;
            end
        end
        if (pal_cs) begin
            pal_dout <= bus.cpu_addr[0] ? {4'h0, pal_ram[cpu_entry].rgb.r}
                                        : pal_ram[cpu_entry].raw[7:0];
        end
    end

    // Char wins unless disabled or transparent
    assign use_char = layer_en[1] && char_pxl[1:0] != 2'd0;
    assign use_scr  = layer_en[0];
    assign sel_word = pal_ram[use_char ? {1'b1, char_pxl} : {1'b0, scr_pxl}];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hbl_sr   <= 2'b11;
            vbl_sr   <= 2'b11;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            pix      <= '0;
        end else if (scan.pxl_cen) begin
            // Blanks follow the two layer stages
            hbl_sr   <= {hbl_sr[0], scan.hbl};
            vbl_sr   <= {vbl_sr[0], scan.vbl};
            lhbl_dly <= ~hbl_sr[1];
            lvbl_dly <= ~vbl_sr[1];
            if (hbl_sr[1] || vbl_sr[1] || !(use_char || use_scr)) begin
                pix <= '0;
            end else begin
                pix <= sel_word;
            end
        end
    end

    assign red   = pix.rgb.r;
    assign green = pix.rgb.g;
    assign blue  = pix.rgb.b;

endmodule

/* hw/video_top.sv */
// Video subsystem top level that maps the board bus and scan signals onto the four video blocks
`timescale 1ns/1ps

module video_top (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       pxl_cen,
    // CPU bus
    input  logic [9:0] cpu_addr,
    input  logic       cpu_wrn,
    input  logic [7:0] cpu_dout,
    input  logic       char_cs,
    input  logic       scr_cs,
    input  logic       pal_cs,
    output logic [7:0] char_dout,
    output logic [7:0] scr_dout,
    output logic [7:0] pal_dout,
    // Scroll and screen control
    input  logic [6:0] scroll_x,
    input  logic [5:0] scroll_y,
    input  logic       flip,
    // Debug layer enables
    input  logic [1:0] layer_en,
    // Video out
    output logic       hs,
    output logic       vs,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    logic [5:0] char_pxl;
    logic [5:0] scr_pxl;

    cpu_bus_if bus ();
    scan_if    scan ();

    assign bus.cpu_addr = cpu_addr;
    assign bus.cpu_wrn  = cpu_wrn;
    assign bus.cpu_dout = cpu_dout;
    assign scan.pxl_cen = pxl_cen;

    video_timing u_timing (
        .clk      ( clk       ),
        .arst_n   ( arst_n    ),
        .flip     ( flip      ),
        .scan     ( scan      ),
        .hs       ( hs        ),
        .vs       ( vs        )
    );

    char_layer u_char (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .bus       ( bus       ),
        .char_cs   ( char_cs   ),
        .char_dout ( char_dout ),
        .scan      ( scan      ),
        .char_pxl  ( char_pxl  )
    );

    scroll_layer u_scroll (
        .clk      ( clk       ),
        .arst_n   ( arst_n    ),
        .bus      ( bus       ),
        .scr_cs   ( scr_cs    ),
        .scr_dout ( scr_dout  ),
        .scan     ( scan      ),
        .scroll_x ( scroll_x  ),
        .scroll_y ( scroll_y  ),
        .scr_pxl  ( scr_pxl   )
    );

    colmix u_colmix (
        .clk      ( clk       ),
        .arst_n   ( arst_n    ),
        .bus      ( bus       ),
        .pal_cs   ( pal_cs    ),
        .pal_dout ( pal_dout  ),
        .scan     ( scan      ),
        .char_pxl ( char_pxl  ),
        .scr_pxl  ( scr_pxl   ),
        .layer_en ( layer_en  ),
        .red      ( red       ),
        .green    ( green     ),
        .blue     ( blue      ),
        .lhbl_dly ( lhbl_dly  ),
        .lvbl_dly ( lvbl_dly  )
    );

endmodule

/* verification/video_chk.sv */
// Sync and blank assertions, bound onto the video top level in every simulation of it
`timescale 1ns/1ps

module video_chk (
    input logic       clk,
    input logic       arst_n,
    input logic       pxl_cen,
    input logic       hs,
    input logic       vs,
    input logic       lhbl_dly,
    input logic       lvbl_dly,
    input logic [3:0] red,
    input logic [3:0] green,
    input logic [3:0] blue
);

    int hs_len;
    int fail_cnt = 0;

    // Pixel enables seen with hs high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_len <= 0;
        end else if (pxl_cen) begin
            hs_len <= hs ? hs_len + 1 : 0;
        end
    end

    hs_width_a: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(hs) |-> hs_len == video_pkg::hs_width)
        else begin
            fail_cnt++;
            $error("hs pulse lasted %0d pixel enables", hs_len);
        end

    // vs moves only at a line boundary, outside the hs pulse
    vs_edge_a: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(vs) |-> !hs && !$past(hs))
        else begin
            fail_cnt++;
            $error("vs changed while hs was high");
        end

    blank_black_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(lhbl_dly && lvbl_dly) |-> {red, green, blue} == 12'h000)
        else begin
            fail_cnt++;
            $error("colour output not black during blanking");
        end

    reset_low_a: assert property (@(posedge clk)
        !arst_n |-> !hs && !vs && !lhbl_dly && !lvbl_dly)
        else begin
            fail_cnt++;
            $error("sync or blank output high during reset");
        end

endmodule

bind video_top video_chk chk0 (.*);

/* verification/video_tb.sv */
// Testbench for the video top level, loads all memories over the bus and checks whole frames
`timescale 1ns/1ps

module video_tb;

    // Columns: flip, scroll_x, scroll_y, layer_en, frames
    localparam int n_rows = 8;
    localparam logic [19:0] scenarios [n_rows] = '{
        {1'b0, 7'd0,   6'd0,  2'b11, 4'd1},
        {1'b0, 7'd127, 6'd63, 2'b11, 4'd1},
        {1'b0, 7'd120, 6'd60, 2'b11, 4'd1},
        {1'b1, 7'd0,   6'd0,  2'b11, 4'd1},
        {1'b1, 7'd5,   6'd62, 2'b11, 4'd1},
        {1'b0, 7'd0,   6'd0,  2'b00, 4'd1},
        {1'b0, 7'd33,  6'd17, 2'b01, 4'd1},
        {1'b0, 7'd0,   6'd0,  2'b10, 4'd2}
    };
    localparam int frame_limit = 3 * video_pkg::h_total * video_pkg::v_total;

    logic       clk;
    logic       arst_n;
    logic       pxl_cen;
    logic [9:0] cpu_addr;
    logic       cpu_wrn;
    logic [7:0] cpu_dout;
    logic       char_cs;
    logic       scr_cs;
    logic       pal_cs;
    logic [7:0] char_dout;
    logic [7:0] scr_dout;
    logic [7:0] pal_dout;
    logic [6:0] scroll_x;
    logic [5:0] scroll_y;
    logic       flip;
    logic [1:0] layer_en;
    logic       hs;
    logic       vs;
    logic       lhbl_dly;
    logic       lvbl_dly;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    logic [31:0] lfsr;
    // Shadows indexed by bus address
    logic [7:0]  char_sh [512];
    logic [7:0]  scr_sh [512];
    logic [7:0]  pal_sh [256];

    video_top dut0 (.*);

    always #20 clk = ~clk;

    // Pixel enable on every second clock
    always @(posedge clk) begin
        #2;
        pxl_cen = ~pxl_cen;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic check(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Error at time %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic drive_bus(input int blk, input int addr, input logic wrn,
                             input logic [7:0] data);
        @(posedge clk);
        #2;
        char_cs  = blk == 0;
        scr_cs   = blk == 1;
        pal_cs   = blk == 2;
        cpu_addr = addr[9:0];
        cpu_wrn  = wrn;
        cpu_dout = data;
    endtask

    task automatic release_bus();
        drive_bus(3, 0, 1'b1, 8'h00);
    endtask

    task automatic write_byte(input int blk, input int addr, input logic [7:0] data);
        drive_bus(blk, addr, 1'b0, data);
        case (blk)
            0: char_sh[addr] = data;
            1: scr_sh[addr] = data;
            default: pal_sh[addr] = data;
        endcase
    endtask

    task automatic load_block(input int blk, input int base, input int n);
        logic [7:0] b;
        for (int a = base; a < base + n; a++) begin
            random_byte(b);
            write_byte(blk, a, b);
        end
        release_bus();
    endtask

    // Read data is registered one clock after the address
    task automatic verify_block(input int blk, input int base, input int n);
        logic [7:0] got;
        logic [7:0] exp;
        for (int a = base; a < base + n; a++) begin
            drive_bus(blk, a, 1'b1, 8'h00);
            release_bus();
            got = blk == 0 ? char_dout : (blk == 1 ? scr_dout : pal_dout);
            exp = blk == 0 ? char_sh[a] : (blk == 1 ? scr_sh[a] : pal_sh[a]);
            if (blk == 2 && a % 2 == 1) begin
                exp = exp & 8'h0f;
            end
            check(got, exp, $sformatf("readback of block %0d address %0d", blk, a));
        end
    endtask

    function automatic logic [5:0] char_pixel(input int x, input int y);
        logic [7:0] code;
        int         row;
        code = char_sh[(y / 8) * video_pkg::char_cols + x / 8];
        row  = 256 + (int'(code[3:0]) * 8 + y % 8) * 2;
        return {code[7:4], char_sh[row + 1][7 - x % 8], char_sh[row][7 - x % 8]};
    endfunction

    function automatic logic [5:0] scroll_pixel(input int x, input int y);
        logic [7:0] code;
        int         row;
        code = scr_sh[(y / 8) * video_pkg::scr_cols + x / 8];
        row  = 256 + (int'(code[3:0]) * 8 + y % 8) * 2;
        return {code[7:4], scr_sh[row + 1][7 - x % 8], scr_sh[row][7 - x % 8]};
    endfunction

    function automatic logic [11:0] expected_rgb(input int x, input int y, input logic fl,
                                                 input int sx, input int sy,
                                                 input logic [1:0] en);
        int         hp;
        int         vp;
        int         idx;
        logic [5:0] c;
        logic [5:0] s;
        hp = fl ? video_pkg::h_visible - 1 - x : x;
        vp = fl ? video_pkg::v_visible - 1 - y : y;
        c  = char_pixel(hp, vp);
        s  = scroll_pixel((hp + sx) % 128, (vp + sy) % 64);
        if (en[1] && c[1:0] != 2'd0) begin
            idx = 64 + int'(c);
        end else if (en[0]) begin
            idx = int'(s);
        end else begin
            return 12'h000;
        end
        return {pal_sh[2 * idx + 1][3:0], pal_sh[2 * idx]};
    endfunction

    // Negedge sample just before the next pixel enable edge
    task automatic next_pixel();
        int n;
        n = 0;
        @(negedge clk);
        while (!pxl_cen) begin
            n++;
            if (n > 4) begin
                timeout_fail("the pixel enable");
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_frame_start(output int vs_n);
        logic prev;
        logic vs_prev;
        int   n;
        n    = 0;
        vs_n = 0;
        do begin
            prev    = lvbl_dly;
            vs_prev = vs;
            next_pixel();
            if (vs && !vs_prev) begin
                vs_n++;
            end
            n++;
            if (n > frame_limit) begin
                timeout_fail("the rising edge of lvbl_dly");
            end
        end while (prev || !lvbl_dly);
    endtask

    task automatic wait_frame_end();
        int n;
        n = 0;
        while (lvbl_dly) begin
            next_pixel();
            n++;
            if (n > frame_limit) begin
                timeout_fail("the falling edge of lvbl_dly");
            end
        end
    endtask

    task automatic check_frame(input int r, input logic fl, input int sx, input int sy,
                               input logic [1:0] en);
        int   x;
        int   y;
        int   n;
        int   hs_n;
        logic hs_prev;
        x       = 0;
        y       = 0;
        n       = 0;
        hs_n    = 0;
        hs_prev = hs;
        while (lvbl_dly) begin
            if (lhbl_dly) begin
                check({red, green, blue}, expected_rgb(x, y, fl, sx, sy, en),
                      $sformatf("row %0d pixel (%0d,%0d)", r, x, y));
                x++;
            end else if (x != 0) begin
                check(x, video_pkg::h_visible, $sformatf("row %0d pixels in line %0d", r, y));
                x = 0;
                y++;
            end
            if (hs && !hs_prev) begin
                hs_n++;
            end
            hs_prev = hs;
            next_pixel();
            n++;
            if (n > frame_limit) begin
                timeout_fail("the end of the visible frame");
            end
        end
        check(y, video_pkg::v_visible, $sformatf("row %0d visible lines", r));
        check(hs_n, video_pkg::v_visible, $sformatf("row %0d hs pulses in frame", r));
    endtask

    initial begin
        int          vs_n;
        logic [19:0] row;
        clk      = 1'b0;
        arst_n   = 1'b0;
        pxl_cen  = 1'b0;
        cpu_addr = '0;
        cpu_wrn  = 1'b1;
        cpu_dout = '0;
        char_cs  = 1'b0;
        scr_cs   = 1'b0;
        pal_cs   = 1'b0;
        scroll_x = '0;
        scroll_y = '0;
        flip     = 1'b0;
        layer_en = 2'b11;
        lfsr     = 32'h48d9e65f;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;

        load_block(0, 0, 32);
        load_block(0, 256, 256);
        load_block(1, 0, 128);
        load_block(1, 256, 256);
        load_block(2, 0, 256);
        verify_block(0, 0, 32);
        verify_block(0, 256, 256);
        verify_block(1, 0, 128);
        verify_block(1, 256, 256);
        verify_block(2, 0, 256);

        // Align to vertical blank before the first row
        wait_frame_start(vs_n);
        wait_frame_end();
        for (int r = 0; r < n_rows; r++) begin
            row = scenarios[r];
            @(posedge clk);
            #2;
            flip     = row[19];
            scroll_x = row[18:12];
            scroll_y = row[11:6];
            layer_en = row[5:4];
            for (int f = 0; f < int'(row[3:0]); f++) begin
                wait_frame_start(vs_n);
                check(vs_n, 1, $sformatf("row %0d vs pulses per frame", r));
                check_frame(r, row[19], int'(row[18:12]), int'(row[11:6]), row[5:4]);
            end
        end

        if (dut0.chk0.fail_cnt != 0) begin
            $display("%0d sync or blank assertions failed", dut0.chk0.fail_cnt);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* src.f */
hw/video_pkg.sv
hw/video_if.sv
hw/video_timing.sv
hw/char_layer.sv
hw/scroll_layer.sv
hw/colmix.sv
hw/video_top.sv
verification/video_chk.sv
verification/video_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= video_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
